// File: design/uart_reg_pkg.sv
package uart_reg_pkg;

	localparam logic [31:0] base_addr = 32'h0000_0400;

	localparam logic [31:0] stack_ofs = 32'd0;
	localparam logic [31:0] ctrl_ofs = 32'd1;
	localparam logic [31:0] ctrl_set_ofs = 32'd2;
	localparam logic [31:0] ctrl_clr_ofs = 32'd3;
	localparam logic [31:0] tx_stat_ofs = 32'd4;
	localparam logic [31:0] tx_stat_set_ofs = 32'd5;
	localparam logic [31:0] tx_stat_clr_ofs = 32'd6;
	localparam logic [31:0] rx_stat_ofs = 32'd7;
	localparam logic [31:0] rx_stat_set_ofs = 32'd8;
	localparam logic [31:0] rx_stat_clr_ofs = 32'd9;

	// index into the seven-bit enable and flag fields
	localparam int flag_frame = 6;
	localparam int flag_parity = 5;
	localparam int flag_noise = 4;
	localparam int flag_underflow = 3;
	localparam int flag_overflow = 2;
	localparam int flag_watermark = 1;
	localparam int flag_level = 0;	// empty flag, enable is tx empty / rx full

	typedef struct packed {
		logic [3:0] reserved;
		logic flow_ctrl;	// rts/cts
		logic parity;	// even parity when set
		logic stop_bits;	// 0: one, 1: two
		logic data_bits;	// 0: seven, 1: eight
		logic [23:0] baud;	// clock cycles per bit
	} ctrl_word_t;

	typedef struct packed {
		logic clear;
		logic [6:0] en;
		logic [6:0] flags;
		logic full;
		logic [7:0] watermark;
		logic [7:0] size;
	} stat_word_t;

	typedef union packed {
		ctrl_word_t ctrl;
		stat_word_t stat;
	} bus_word_u;

	// software writable bits of each register
	localparam logic [31:0] ctrl_wmask = 32'h0FFF_FFFF;
	localparam logic [31:0] tx_stat_wmask = 32'h8708_FF00;
	localparam logic [31:0] rx_stat_wmask = 32'hFFF8_FF00;

	localparam ctrl_word_t ctrl_reset = '{
		reserved: 4'h0,
		flow_ctrl: 1'b1,
		parity: 1'b1,
		stop_bits: 1'b0,
		data_bits: 1'b1,
		baud: 24'd69
	};
	localparam logic [31:0] tx_stat_reset = 32'h0000_0000;
	localparam logic [31:0] rx_stat_reset = 32'h0000_0100;	// watermark 1

endpackage

// File: design/uart_line_pkg.sv
package uart_line_pkg;

	localparam int tx_addr_width = 4;	// 16 entries
	localparam int rx_addr_width = 4;
	localparam int baud_width = 24;

	// index of the last data bit
	localparam logic [2:0] last_bit_7 = 3'd6;
	localparam logic [2:0] last_bit_8 = 3'd7;

	// rx start is seen one cycle late after the synchronizer
	localparam logic [baud_width-1:0] start_cnt = baud_width'(1);
	localparam logic [baud_width-1:0] sample_spread = baud_width'(1);	// around mid bit

	// frame states, shared by tx and rx
	localparam logic [2:0] st_idle = 3'd0;
	localparam logic [2:0] st_start = 3'd1;
	localparam logic [2:0] st_data = 3'd2;
	localparam logic [2:0] st_parity = 3'd3;
	localparam logic [2:0] st_stop = 3'd4;

endpackage

// File: design/uart_cfg_if.sv
`timescale 1ns/1ps

interface uart_cfg_if;

	logic flow_ctrl;
	logic parity;
	logic stop_bits;
	logic data_bits;
	logic [uart_line_pkg::baud_width-1:0] baud;

	// register block side
	modport regs (output flow_ctrl, parity, stop_bits, data_bits, baud);

	// serializer side
	modport line (input flow_ctrl, parity, stop_bits, data_bits, baud);

endinterface

// File: design/byte_fifo.sv
`timescale 1ns/1ps

module byte_fifo #(
	parameter int addr_width = 4
) (
	input logic clk,
	input logic reset,
	input logic clear,
	input logic push,
	input logic [7:0] din,
	input logic pop,
	output logic [7:0] dout,
	output logic [addr_width:0] size,
	output logic empty,
	output logic full
);

	logic [7:0] mem [2**addr_width];
	logic [addr_width-1:0] rd_ptr;
	logic [addr_width-1:0] wr_ptr;
	logic [addr_width:0] count;
	logic do_push;
	logic do_pop;

	assign size = count;
	assign empty = count == '0;
	assign full = count[addr_width];	// count reaches depth
	assign do_push = push && !full;
	assign do_pop = pop && !empty;
	assign dout = mem[rd_ptr];	// head, no latency

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else if (clear) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

endmodule

// File: design/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
	input logic clk,
	input logic reset,
	uart_cfg_if.line cfg,
	input logic clear,
	input logic push,
	input logic [7:0] data_in,
	output logic [uart_line_pkg::tx_addr_width:0] size,
	output logic empty,
	output logic full,
	input logic cts,
	output logic tx
);

	logic [2:0] state;
	logic [2:0] bit_cnt;
	logic [uart_line_pkg::baud_width-1:0] cnt;
	logic [uart_line_pkg::baud_width-1:0] baud_q;
	logic [7:0] fifo_dout;
	logic [7:0] shift;
	logic par_q;
	logic data_bits_q;
	logic parity_q;
	logic stop_bits_q;
	logic start_frame;
	logic bit_end;
	logic [2:0] last_bit;

	assign start_frame = state == uart_line_pkg::st_idle && !empty && !(cfg.flow_ctrl && cts);
	assign bit_end = cnt == baud_q - 1'b1;
	assign last_bit = data_bits_q ? uart_line_pkg::last_bit_8 : uart_line_pkg::last_bit_7;

	byte_fifo #(.addr_width(uart_line_pkg::tx_addr_width)) fifo (
		.clk(clk),
		.reset(reset),
		.clear(clear),
		.push(push),
		.din(data_in),
		.pop(start_frame),	// popped as the frame starts
		.dout(fifo_dout),
		.size(size),
		.empty(empty),
		.full(full)
	);

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			state <= uart_line_pkg::st_idle;
			tx <= 1'b1;
			cnt <= '0;
			bit_cnt <= '0;
		end else if (clear) begin
			state <= uart_line_pkg::st_idle;
			tx <= 1'b1;
		end else if (state == uart_line_pkg::st_idle) begin
			if (start_frame) begin
				state <= uart_line_pkg::st_start;
				tx <= 1'b0;
				cnt <= '0;
			end
		end else if (!bit_end) begin
			cnt <= cnt + 1'b1;
		end else begin
			cnt <= '0;
			case (state)
				uart_line_pkg::st_start: begin
					state <= uart_line_pkg::st_data;
					tx <= shift[0];	// lsb first
					bit_cnt <= '0;
				end
				uart_line_pkg::st_data: begin
					if (bit_cnt != last_bit) begin
						bit_cnt <= bit_cnt + 1'b1;
						tx <= shift[bit_cnt + 3'd1];
					end else if (parity_q) begin
						state <= uart_line_pkg::st_parity;
						tx <= par_q;
					end else begin
						state <= uart_line_pkg::st_stop;
						tx <= 1'b1;
						bit_cnt <= '0;
					end
				end
				uart_line_pkg::st_parity: begin
					state <= uart_line_pkg::st_stop;
					tx <= 1'b1;
					bit_cnt <= '0;
				end
				default: begin
					if (stop_bits_q && bit_cnt == 3'd0)
						bit_cnt <= 3'd1;	// second stop bit
					else
						state <= uart_line_pkg::st_idle;
				end
			endcase
		end
	end

	// frame settings are fixed for the whole frame
	always_ff @(posedge clk) begin
		if (start_frame) begin
			shift <= fifo_dout;
			par_q <= cfg.data_bits ? ^fifo_dout : ^fifo_dout[6:0];
			data_bits_q <= cfg.data_bits;
			parity_q <= cfg.parity;
			stop_bits_q <= cfg.stop_bits;
			baud_q <= cfg.baud;
		end
	end

endmodule

// File: design/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
	input logic clk,
	input logic reset,
	uart_cfg_if.line cfg,
	input logic clear,
	input logic pop,
	output logic [7:0] data_out,
	output logic [uart_line_pkg::rx_addr_width:0] size,
	output logic empty,
	output logic full,
	input logic rx,
	output logic rts,
	output logic noise_error,
	output logic parity_error,
	output logic frame_error,
	output logic overflow_error
);

	logic rx_s1;
	logic rx_s2;
	logic rx_d;
	logic [2:0] state;
	logic [2:0] bit_cnt;
	logic [uart_line_pkg::baud_width-1:0] cnt;
	logic [uart_line_pkg::baud_width-1:0] baud_q;
	logic [uart_line_pkg::baud_width-1:0] mid;
	logic data_bits_q;
	logic parity_q;
	logic stop_bits_q;
	logic noise_q;
	logic par_err_q;
	logic frame_q;
	logic [1:0] smp;
	logic [7:0] data_q;
	logic [7:0] byte_out;
	logic [2:0] last_bit;
	logic fall;
	logic sample;
	logic decide;
	logic bit_end;
	logic maj;
	logic noisy;
	logic last_stop;
	logic frame_done;

	assign fall = rx_d && !rx_s2;
	assign mid = baud_q >> 1;
	assign sample = cnt == mid - uart_line_pkg::sample_spread || cnt == mid;
	assign decide = cnt == mid + uart_line_pkg::sample_spread;	// third sample
	assign bit_end = cnt == baud_q - 1'b1;
	assign maj = smp[1] && smp[0] || smp[1] && rx_s2 || smp[0] && rx_s2;
	assign noisy = !(smp[1] == smp[0] && smp[0] == rx_s2);
	assign last_stop = !stop_bits_q || bit_cnt != 3'd0;
	assign frame_done = state == uart_line_pkg::st_stop && decide && last_stop;
	assign last_bit = data_bits_q ? uart_line_pkg::last_bit_8 : uart_line_pkg::last_bit_7;
	assign byte_out = data_bits_q ? data_q : {1'b0, data_q[6:0]};

	assign rts = cfg.flow_ctrl && full;
	assign noise_error = frame_done && (noise_q || noisy);
	assign parity_error = frame_done && par_err_q;
	assign frame_error = frame_done && (frame_q || !maj);
	assign overflow_error = frame_done && full;	// byte dropped by the fifo

	byte_fifo #(.addr_width(uart_line_pkg::rx_addr_width)) fifo (
		.clk(clk),
		.reset(reset),
		.clear(clear),
		.push(frame_done),
		.din(byte_out),
		.pop(pop),
		.dout(data_out),
		.size(size),
		.empty(empty),
		.full(full)
	);

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			rx_s1 <= 1'b1;
			rx_s2 <= 1'b1;
			rx_d <= 1'b1;
			state <= uart_line_pkg::st_idle;
			cnt <= '0;
			bit_cnt <= '0;
			baud_q <= '0;
			data_bits_q <= 1'b0;
			parity_q <= 1'b0;
			stop_bits_q <= 1'b0;
			noise_q <= 1'b0;
			par_err_q <= 1'b0;
			frame_q <= 1'b0;
		end else begin
			rx_s1 <= rx;
			rx_s2 <= rx_s1;
			rx_d <= rx_s2;
			if (clear) begin
				state <= uart_line_pkg::st_idle;
			end else if (state == uart_line_pkg::st_idle) begin
				if (fall) begin
					state <= uart_line_pkg::st_start;
					cnt <= uart_line_pkg::start_cnt;
					data_bits_q <= cfg.data_bits;
					parity_q <= cfg.parity;
					stop_bits_q <= cfg.stop_bits;
					baud_q <= cfg.baud;
					noise_q <= 1'b0;
					par_err_q <= 1'b0;
					frame_q <= 1'b0;
				end
			end else begin
				cnt <= bit_end ? '0 : cnt + 1'b1;
				if (bit_end) begin
					case (state)
						uart_line_pkg::st_start: begin
							state <= uart_line_pkg::st_data;
							bit_cnt <= '0;
						end
						uart_line_pkg::st_data: begin
							if (bit_cnt == last_bit) begin
								state <= parity_q ? uart_line_pkg::st_parity
									: uart_line_pkg::st_stop;
								bit_cnt <= '0;
							end else begin
								bit_cnt <= bit_cnt + 1'b1;
							end
						end
						uart_line_pkg::st_parity: begin
							state <= uart_line_pkg::st_stop;
							bit_cnt <= '0;
						end
						default: bit_cnt <= 3'd1;	// into second stop bit
					endcase
				end
				if (decide) begin
					noise_q <= noise_q || noisy;
					case (state)
						uart_line_pkg::st_start: begin
							if (maj)
								state <= uart_line_pkg::st_idle;	// glitch
						end
						uart_line_pkg::st_parity: par_err_q <= maj != ^byte_out;
						uart_line_pkg::st_stop: begin
							frame_q <= frame_q || !maj;
							if (last_stop)
								state <= uart_line_pkg::st_idle;
						end
						default: ;
					endcase
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sample)
			smp <= {smp[0], rx_s2};
		if (state == uart_line_pkg::st_data && decide)
			data_q[bit_cnt] <= maj;
	end

endmodule

// File: design/uart.sv
`timescale 1ns/1ps

module uart (
	input logic clk,
	input logic reset,
	input logic [31:0] addr,
	input logic [31:0] wdata,
	input logic write,
	output logic [31:0] rdata,
	output logic tx,
	input logic rx,
	input logic cts,
	output logic rts,
	output logic irq
);

	logic [31:0] addr_q;
	logic write_q;
	logic [31:0] ofs;
	logic [31:0] rd_ofs;
	uart_reg_pkg::bus_word_u wd;
	uart_reg_pkg::ctrl_word_t ctrl_q;
	uart_reg_pkg::stat_word_t tx_stat_q;
	uart_reg_pkg::stat_word_t tx_stat_d;
	uart_reg_pkg::stat_word_t tx_rd;
	uart_reg_pkg::stat_word_t rx_stat_q;
	uart_reg_pkg::stat_word_t rx_stat_d;
	uart_reg_pkg::stat_word_t rx_rd;
	logic ctrl_we;
	logic tx_we;
	logic rx_we;
	logic op_set;
	logic op_clr;
	logic push;
	logic pop;
	logic [7:0] rx_dout;
	logic [uart_line_pkg::tx_addr_width:0] tx_size;
	logic [uart_line_pkg::rx_addr_width:0] rx_size;
	logic tx_empty;
	logic tx_full;
	logic rx_empty;
	logic rx_full;
	logic tx_watermark_reached;
	logic rx_watermark_reached;
	logic noise_w;
	logic parity_w;
	logic frame_w;
	logic overflow_w;

	uart_cfg_if cfg ();

	// register write, set alias (or) and clear alias (and not)
	function automatic logic [31:0] apply(input logic [31:0] cur, input logic [31:0] din,
		input logic set, input logic clr);
		if (set)
			return cur | din;
		if (clr)
			return cur & ~din;
		return din;
	endfunction

	assign wd = wdata;
	assign ofs = addr - uart_reg_pkg::base_addr;
	assign rd_ofs = addr_q - uart_reg_pkg::base_addr;

	assign push = write && ofs == uart_reg_pkg::stack_ofs;
	assign pop = !write_q && rd_ofs == uart_reg_pkg::stack_ofs;	// at end of data cycle
	assign ctrl_we = write && (ofs == uart_reg_pkg::ctrl_ofs
		|| ofs == uart_reg_pkg::ctrl_set_ofs || ofs == uart_reg_pkg::ctrl_clr_ofs);
	assign tx_we = write && (ofs == uart_reg_pkg::tx_stat_ofs
		|| ofs == uart_reg_pkg::tx_stat_set_ofs || ofs == uart_reg_pkg::tx_stat_clr_ofs);
	assign rx_we = write && (ofs == uart_reg_pkg::rx_stat_ofs
		|| ofs == uart_reg_pkg::rx_stat_set_ofs || ofs == uart_reg_pkg::rx_stat_clr_ofs);
	assign op_set = ofs == uart_reg_pkg::ctrl_set_ofs || ofs == uart_reg_pkg::tx_stat_set_ofs
		|| ofs == uart_reg_pkg::rx_stat_set_ofs;
	assign op_clr = ofs == uart_reg_pkg::ctrl_clr_ofs || ofs == uart_reg_pkg::tx_stat_clr_ofs
		|| ofs == uart_reg_pkg::rx_stat_clr_ofs;

	assign cfg.flow_ctrl = ctrl_q.flow_ctrl;
	assign cfg.parity = ctrl_q.parity;
	assign cfg.stop_bits = ctrl_q.stop_bits;
	assign cfg.data_bits = ctrl_q.data_bits;
	assign cfg.baud = ctrl_q.baud;

	assign tx_watermark_reached = 8'(tx_size) <= tx_stat_q.watermark;
	assign rx_watermark_reached = 8'(rx_size) >= rx_stat_q.watermark;

	// sticky flags, a pulse wins over a software write in the same cycle
	always_comb begin
		tx_stat_d = tx_stat_q;
		tx_stat_d.clear = 1'b0;	// one cycle pulse
		if (tx_we)
			tx_stat_d = apply(tx_stat_q, wd.stat, op_set, op_clr) & uart_reg_pkg::tx_stat_wmask;
		tx_stat_d.flags[uart_reg_pkg::flag_overflow] =
			tx_stat_d.flags[uart_reg_pkg::flag_overflow] || (push && tx_full);
		rx_stat_d = rx_stat_q;
		rx_stat_d.clear = 1'b0;
		if (rx_we)
			rx_stat_d = apply(rx_stat_q, wd.stat, op_set, op_clr) & uart_reg_pkg::rx_stat_wmask;
		rx_stat_d.flags[uart_reg_pkg::flag_frame] =
			rx_stat_d.flags[uart_reg_pkg::flag_frame] || frame_w;
		rx_stat_d.flags[uart_reg_pkg::flag_parity] =
			rx_stat_d.flags[uart_reg_pkg::flag_parity] || parity_w;
		rx_stat_d.flags[uart_reg_pkg::flag_noise] =
			rx_stat_d.flags[uart_reg_pkg::flag_noise] || noise_w;
		rx_stat_d.flags[uart_reg_pkg::flag_underflow] =
			rx_stat_d.flags[uart_reg_pkg::flag_underflow] || (pop && rx_empty);
		rx_stat_d.flags[uart_reg_pkg::flag_overflow] =
			rx_stat_d.flags[uart_reg_pkg::flag_overflow] || overflow_w;
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			addr_q <= '0;
			write_q <= 1'b1;	// no pop and zero rdata out of reset
			ctrl_q <= uart_reg_pkg::ctrl_reset;
			tx_stat_q <= uart_reg_pkg::tx_stat_reset;
			rx_stat_q <= uart_reg_pkg::rx_stat_reset;
		end else begin
			addr_q <= addr;
			write_q <= write;
			if (ctrl_we)
				ctrl_q <= apply(ctrl_q, wd.ctrl, op_set, op_clr) & uart_reg_pkg::ctrl_wmask;
			tx_stat_q <= tx_stat_d;
			rx_stat_q <= rx_stat_d;
		end
	end

	// status words as read, with the live fifo bits merged in
	always_comb begin
		tx_rd = tx_stat_q;
		tx_rd.clear = 1'b0;
		tx_rd.flags[uart_reg_pkg::flag_watermark] = tx_watermark_reached;
		tx_rd.flags[uart_reg_pkg::flag_level] = tx_empty;
		tx_rd.full = tx_full;
		tx_rd.size = 8'(tx_size);
		rx_rd = rx_stat_q;
		rx_rd.clear = 1'b0;
		rx_rd.flags[uart_reg_pkg::flag_watermark] = rx_watermark_reached;
		rx_rd.flags[uart_reg_pkg::flag_level] = rx_empty;
		rx_rd.full = rx_full;
		rx_rd.size = 8'(rx_size);
	end

	// rx level enable goes with full, not empty
	assign irq = |(tx_rd.en & tx_rd.flags) || |(rx_rd.en & {rx_rd.flags[6:1], rx_full});

	always_comb begin
		rdata = '0;
		if (!write_q) begin
			case (rd_ofs)
				uart_reg_pkg::stack_ofs: rdata = {24'h000000, rx_empty ? 8'h00 : rx_dout};
				uart_reg_pkg::ctrl_ofs: rdata = ctrl_q;
				uart_reg_pkg::tx_stat_ofs: rdata = tx_rd;
				uart_reg_pkg::rx_stat_ofs: rdata = rx_rd;
				default: ;
			endcase
		end
	end

	uart_tx transmitter (
		.clk(clk),
		.reset(reset),
		.cfg(cfg),
		.clear(tx_stat_q.clear),
		.push(push),
		.data_in(wdata[7:0]),
		.size(tx_size),
		.empty(tx_empty),
		.full(tx_full),
		.cts(cts),
		.tx(tx)
	);

	uart_rx receiver (
		.clk(clk),
		.reset(reset),
		.cfg(cfg),
		.clear(rx_stat_q.clear),
		.pop(pop),
		.data_out(rx_dout),
		.size(rx_size),
		.empty(rx_empty),
		.full(rx_full),
		.rx(rx),
		.rts(rts),
		.noise_error(noise_w),
		.parity_error(parity_w),
		.frame_error(frame_w),
		.overflow_error(overflow_w)
	);

endmodule

// File: test/uart_checker.sv
`timescale 1ns/1ps

module uart_checker (
	input logic clk,
	input logic reset,
	input logic write,
	input logic [31:0] rdata,
	input logic irq,
	input logic tx,
	input logic rts,
	input logic flow_ctrl,
	input logic [2:0] tx_state,
	input logic [uart_line_pkg::tx_addr_width:0] tx_size,
	input logic [uart_line_pkg::rx_addr_width:0] rx_size,
	input uart_reg_pkg::stat_word_t tx_stat,
	input uart_reg_pkg::stat_word_t rx_stat
);

	localparam int rx_depth = 2 ** uart_line_pkg::rx_addr_width;

	int unsigned fail_count = 0;
	logic tx_empty_now;
	logic tx_wm_now;
	logic rx_wm_now;
	logic rx_full_now;
	logic [6:0] tx_flags;
	logic [6:0] rx_flags;

	// level and watermark bits rebuilt from the fifo sizes
	assign tx_empty_now = tx_size == '0;
	assign tx_wm_now = 8'(tx_size) <= tx_stat.watermark;
	assign rx_wm_now = 8'(rx_size) >= rx_stat.watermark;
	assign rx_full_now = int'(rx_size) == rx_depth;
	assign tx_flags = {tx_stat.flags[6:2], tx_wm_now, tx_empty_now};
	assign rx_flags = {rx_stat.flags[6:2], rx_wm_now, rx_full_now};	// rx level enable pairs with full

	irq_follows_flags: assert property (@(posedge clk) disable iff (reset)
		irq == (|(tx_stat.en & tx_flags) || |(rx_stat.en & rx_flags)))
	else begin
		fail_count++;
		$error("irq does not match the enabled status flags");
	end

	tx_high_when_idle: assert property (@(posedge clk) disable iff (reset)
		tx_state == uart_line_pkg::st_idle |-> tx)
	else begin
		fail_count++;
		$error("tx line is low while the transmitter is idle");
	end

	rts_only_when_full: assert property (@(posedge clk) disable iff (reset)
		rts == (flow_ctrl && rx_full_now))
	else begin
		fail_count++;
		$error("rts does not follow flow control and a full rx fifo");
	end

	rdata_zero_after_write: assert property (@(posedge clk) disable iff (reset)
		write |=> rdata == '0)
	else begin
		fail_count++;
		$error("rdata is not zero in the cycle after a write");
	end

endmodule

// File: test/uart_tb.sv
`timescale 1ns/1ps

module uart_tb;

	localparam logic [31:0] idle_addr = uart_reg_pkg::base_addr + 32'h100;	// unmapped
	localparam int bit_cycles = 8;
	localparam int ovf_bit = 17 + uart_reg_pkg::flag_overflow;
	localparam int ovf_en = 24 + uart_reg_pkg::flag_overflow;
	localparam int unf_bit = 17 + uart_reg_pkg::flag_underflow;
	localparam int par_bit = 17 + uart_reg_pkg::flag_parity;
	localparam int frm_bit = 17 + uart_reg_pkg::flag_frame;
	localparam int lvl_bit = 17 + uart_reg_pkg::flag_level;
	localparam int wm_en = 24 + uart_reg_pkg::flag_watermark;

	logic clk;
	logic reset;
	logic [31:0] addr;
	logic [31:0] wdata;
	logic write;
	logic [31:0] rdata;
	logic tx;
	logic rx_line;
	logic cts;
	logic rts;
	logic irq;
	logic loop_sel;
	logic bb_line;
	logic [31:0] seed;
	logic [31:0] rd_val;
	logic [7:0] first_byte;
	int errors;
	int timeouts;
	int total;

	assign rx_line = loop_sel ? tx : bb_line;

	uart dut (
		.clk(clk),
		.reset(reset),
		.addr(addr),
		.wdata(wdata),
		.write(write),
		.rdata(rdata),
		.tx(tx),
		.rx(rx_line),
		.cts(cts),
		.rts(rts),
		.irq(irq)
	);

	bind uart uart_checker chk (
		.clk(clk),
		.reset(reset),
		.write(write),
		.rdata(rdata),
		.irq(irq),
		.tx(tx),
		.rts(rts),
		.flow_ctrl(ctrl_q.flow_ctrl),
		.tx_state(transmitter.state),
		.tx_size(tx_size),
		.rx_size(rx_size),
		.tx_stat(tx_stat_q),
		.rx_stat(rx_stat_q)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic expect_equal(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		assert (got === exp)
		else begin
			errors++;
			$display("FAILED %s: expected %h, actual %h", name, exp, got);
		end
	endtask

	// every task starts and ends 1 ns after a rising edge
	task automatic bus_write(input logic [31:0] ofs, input logic [31:0] data);
		addr = uart_reg_pkg::base_addr + ofs;
		wdata = data;
		write = 1'b1;
		@(posedge clk);
		#1;
		write = 1'b0;
		addr = idle_addr;
	endtask

	task automatic bus_read(input logic [31:0] ofs, output logic [31:0] data);
		addr = uart_reg_pkg::base_addr + ofs;
		write = 1'b0;
		@(posedge clk);
		#1;
		addr = idle_addr;
		data = rdata;	// data cycle
		@(posedge clk);
		#1;
	endtask

	task automatic wait_field(input string what, input logic [31:0] ofs, input logic [31:0] mask,
		input logic [31:0] value, input int limit, output logic [31:0] data);
		int n;
		n = 0;
		bus_read(ofs, data);
		while ((data & mask) != value && n < limit) begin
			bus_read(ofs, data);
			n++;
		end
		if ((data & mask) != value) begin
			timeouts++;
			$display("timeout while waiting for %s", what);
		end
	endtask

	// 8 data bits, one parity bit, one stop bit, then one idle bit
	task automatic bit_bang(input logic [7:0] data, input logic par, input logic stop);
		logic [10:0] frame;
		frame = {stop, par, data, 1'b0};
		for (int i = 0; i < 11; i++) begin
			bb_line = frame[i];
			repeat (bit_cycles) @(posedge clk);
			#1;
		end
		bb_line = 1'b1;
		repeat (bit_cycles) @(posedge clk);
		#1;
	endtask

	task automatic loopback(input string name, input logic eight);
		logic [7:0] sent [12];
		logic [31:0] d;
		for (int i = 0; i < 12; i++) begin
			seed = xorshift(seed);
			sent[i] = seed[7:0];
			bus_write(uart_reg_pkg::stack_ofs, {24'h0, sent[i]});
		end
		wait_field({name, " rx size"}, uart_reg_pkg::rx_stat_ofs, 32'hff, 32'd12, 2000, d);
		for (int i = 0; i < 12; i++) begin
			bus_read(uart_reg_pkg::stack_ofs, d);
			expect_equal(name, {24'h0, eight ? sent[i] : {1'b0, sent[i][6:0]}}, d);
		end
	endtask

	initial begin
		errors = 0;
		timeouts = 0;
		seed = 32'hc3116326;
		addr = idle_addr;
		wdata = '0;
		write = 1'b0;
		cts = 1'b0;
		loop_sel = 1'b1;
		bb_line = 1'b1;
		reset = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		// control register and its aliases
		bus_read(uart_reg_pkg::ctrl_ofs, rd_val);
		expect_equal("ctrl reset", 32'h0D00_0045, rd_val);
		bus_write(uart_reg_pkg::ctrl_set_ofs, 32'h0200_0000);
		bus_read(uart_reg_pkg::ctrl_ofs, rd_val);
		expect_equal("ctrl set alias", 32'h0F00_0045, rd_val);
		bus_write(uart_reg_pkg::ctrl_clr_ofs, 32'h0400_0000);
		bus_read(uart_reg_pkg::ctrl_ofs, rd_val);
		expect_equal("ctrl clear alias", 32'h0B00_0045, rd_val);
		bus_write(uart_reg_pkg::ctrl_ofs, 32'h0100_0010);
		bus_read(uart_reg_pkg::ctrl_ofs, rd_val);
		expect_equal("ctrl plain write", 32'h0100_0010, rd_val);
		bus_read(uart_reg_pkg::tx_stat_ofs, rd_val);
		expect_equal("tx watermark reset", 32'd0, {24'h0, rd_val[15:8]});
		bus_read(uart_reg_pkg::rx_stat_ofs, rd_val);
		expect_equal("rx watermark reset", 32'd1, {24'h0, rd_val[15:8]});

		// baud 8, even parity, flow control
		bus_write(uart_reg_pkg::ctrl_ofs, 32'h0D00_0008);
		loopback("loopback 8 bit", 1'b1);
		bus_write(uart_reg_pkg::ctrl_clr_ofs, 32'h0100_0000);
		loopback("loopback 7 bit", 1'b0);

		cts = 1'b1;	// hold off the transmitter
		for (int i = 0; i < 17; i++) begin
			seed = xorshift(seed);
			bus_write(uart_reg_pkg::stack_ofs, {24'h0, seed[7:0]});
		end
		bus_read(uart_reg_pkg::tx_stat_ofs, rd_val);
		expect_equal("tx size when full", 32'd16, {24'h0, rd_val[7:0]});
		expect_equal("tx full", 32'd1, {31'h0, rd_val[16]});
		expect_equal("tx overflow flag", 32'd1, {31'h0, rd_val[ovf_bit]});
		bus_write(uart_reg_pkg::tx_stat_set_ofs, 32'h1 << ovf_en);
		expect_equal("irq on tx overflow", 32'd1, {31'h0, irq});
		bus_write(uart_reg_pkg::tx_stat_clr_ofs, 32'h1 << ovf_bit);
		expect_equal("irq after overflow clear", 32'd0, {31'h0, irq});
		bus_write(uart_reg_pkg::tx_stat_set_ofs, 32'h8000_0000);
		bus_read(uart_reg_pkg::tx_stat_ofs, rd_val);
		expect_equal("tx size after clear", 32'd0, {24'h0, rd_val[7:0]});
		expect_equal("tx empty after clear", 32'd1, {31'h0, rd_val[lvl_bit]});
		cts = 1'b0;

		// bit-banged frames with errors
		bus_write(uart_reg_pkg::ctrl_ofs, 32'h0D00_0008);
		loop_sel = 1'b0;
		seed = xorshift(seed);
		bit_bang(seed[7:0], ~^seed[7:0], 1'b1);	// wrong parity
		seed = xorshift(seed);
		bit_bang(seed[7:0], ^seed[7:0], 1'b0);	// zero stop bit
		wait_field("two error frames", uart_reg_pkg::rx_stat_ofs, 32'hff, 32'd2, 100, rd_val);
		expect_equal("rx parity flag", 32'd1, {31'h0, rd_val[par_bit]});
		expect_equal("rx frame flag", 32'd1, {31'h0, rd_val[frm_bit]});
		for (int i = 0; i < 20 && rd_val[7:0] != 8'd0; i++) begin
			bus_read(uart_reg_pkg::stack_ofs, rd_val);
			bus_read(uart_reg_pkg::rx_stat_ofs, rd_val);
		end
		expect_equal("rx size after draining", 32'd0, {24'h0, rd_val[7:0]});
		bus_read(uart_reg_pkg::stack_ofs, rd_val);
		bus_read(uart_reg_pkg::rx_stat_ofs, rd_val);
		expect_equal("rx underflow flag", 32'd1, {31'h0, rd_val[unf_bit]});

		// watermark 12 with its enable, sticky flags cleared
		bus_write(uart_reg_pkg::rx_stat_ofs, (32'h1 << wm_en) | 32'h0000_0C00);
		expect_equal("irq below watermark", 32'd0, {31'h0, irq});
		for (int i = 0; i < 16; i++) begin
			seed = xorshift(seed);
			if (i == 0)
				first_byte = seed[7:0];
			bit_bang(seed[7:0], ^seed[7:0], 1'b1);
			wait_field("rx fill", uart_reg_pkg::rx_stat_ofs, 32'hff, 32'(i + 1), 20, rd_val);
			expect_equal("irq against rx watermark", {31'h0, i + 1 >= 12}, {31'h0, irq});
		end
		expect_equal("rts on full rx fifo", 32'd1, {31'h0, rts});
		expect_equal("rx full", 32'd1, {31'h0, rd_val[16]});
		seed = xorshift(seed);
		bit_bang(seed[7:0], ^seed[7:0], 1'b1);
		wait_field("rx overflow flag", uart_reg_pkg::rx_stat_ofs, 32'h1 << ovf_bit,
			32'h1 << ovf_bit, 20, rd_val);
		bus_read(uart_reg_pkg::stack_ofs, rd_val);
		expect_equal("first byte of full fifo", {24'h0, first_byte}, rd_val);
		expect_equal("rts after one pop", 32'd0, {31'h0, rts});

		total = errors + timeouts + dut.chk.fail_count;
		$display("errors: %0d wrong values, %0d timeouts, %0d assertion failures",
			errors, timeouts, dut.chk.fail_count);
		if (total == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: project.f
design/uart_reg_pkg.sv
design/uart_line_pkg.sv
design/uart_cfg_if.sv
design/byte_fifo.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart.sv
test/uart_checker.sv
test/uart_tb.sv

// File: Bender.yml
package:
  name: uart

sources:
  - design/uart_reg_pkg.sv
  - design/uart_line_pkg.sv
  - design/uart_cfg_if.sv
  - design/byte_fifo.sv
  - design/uart_tx.sv
  - design/uart_rx.sv
  - design/uart.sv
  - target: test
    files:
      - test/uart_checker.sv
      - test/uart_tb.sv
